// File: Bender.yml
package:
  name: mini_tile

sources:
  # Packages first, then RTL in dependency order
  - files:
      - source/tile_fabric_pkg.sv
      - source/tile_mem_pkg.sv
      - source/dual_port_mem.sv
      - source/trans_fifo.sv
      - source/fabric_out_arb.sv
      - source/f2c_decode.sv
      - source/tile_mem_wrap.sv

  # Testbench
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tile_mem_tb.sv

// File: mini_tile.f
source/tile_fabric_pkg.sv
source/tile_mem_pkg.sv
source/dual_port_mem.sv
source/trans_fifo.sv
source/fabric_out_arb.sv
source/f2c_decode.sv
source/tile_mem_wrap.sv
verif/tb_clock_gen.sv
verif/tile_mem_tb.sv

// File: source/dual_port_mem.sv
/*
 * Behavioral two-port RAM, byte-lane writes on both ports,
 * registered read data on both ports
 */
`default_nettype none

module dual_port_mem #(
    parameter int WORD_WIDTH = 32,
    parameter int ADRS_WIDTH = 13
) (
    input  logic                    Clock,
    // Port A
    input  logic [ADRS_WIDTH-1:0]   address_a,
    input  logic [WORD_WIDTH-1:0]   data_a,
    input  logic                    wren_a,
    input  logic [WORD_WIDTH/8-1:0] byteena_a,
    output logic [WORD_WIDTH-1:0]   q_a,
    // Port B
    input  logic [ADRS_WIDTH-1:0]   address_b,
    input  logic [WORD_WIDTH-1:0]   data_b,
    input  logic                    wren_b,
    input  logic [WORD_WIDTH/8-1:0] byteena_b,
    output logic [WORD_WIDTH-1:0]   q_b
);

    localparam int LANES = WORD_WIDTH / 8;
    localparam int WORDS = 1 << ADRS_WIDTH;

    logic [WORD_WIDTH-1:0] mem [WORDS]; // Storage array

    // Both ports in one process, port B wins a same-word collision
    always_ff @(posedge Clock) begin
        for (int i = 0; i < LANES; i++) begin
            if (wren_a && byteena_a[i])
                mem[address_a][i*8 +: 8] <= data_a[i*8 +: 8];
            if (wren_b && byteena_b[i])
                mem[address_b][i*8 +: 8] <= data_b[i*8 +: 8];
        end
        q_a <= mem[address_a]; // Old data on read-during-write
        q_b <= mem[address_b];
    end

endmodule

`default_nettype wire

// File: source/f2c_decode.sv
/*
 * Fabric to core decode: region hit, memory write enables,
 * read tracking and RD_RSP build toward the response FIFO
 */
`default_nettype none

module f2c_decode
    import tile_fabric_pkg::*;
    import tile_mem_pkg::*;
(
    input  logic        Clock,
    input  logic        rst_n,
    input  t_tile_id    local_tile_id,
    // Incoming fabric transaction
    input  logic        in_fabric_valid,
    input  t_tile_trans in_fabric,
    // Port B read data, one cycle after the address
    input  logic [31:0] imem_q,
    input  logic [31:0] dmem_q,
    // Port B controls
    output logic [31:0] mem_address,
    output logic [31:0] mem_wr_data,
    output logic        imem_wren,
    output logic        dmem_wren,
    // Response FIFO push
    output logic        rsp_push,
    output t_tile_trans rsp_trans
);

    logic [7:0]  region;
    logic        imem_hit;
    logic        dmem_hit;
    logic        is_wr;
    logic        is_rd;
    logic        rd_imem_hit; // Hit selection of the pending read
    logic        rd_dmem_hit;
    logic [31:0] rd_rsp_addr; // Reply address of the pending read
    logic [31:0] rsp_data;

    //======================================================================
    // Request cycle
    //======================================================================
    assign region = in_fabric.address[MSB_REGION:LSB_REGION];

    // Instruction memory first, data memory only on a miss there
    assign imem_hit = (region > I_MEM_REGION_FLOOR) && (region < I_MEM_REGION_ROOF);
    assign dmem_hit = !imem_hit &&
                      (region > D_MEM_REGION_FLOOR) && (region < D_MEM_REGION_ROOF);

    assign is_wr = in_fabric_valid && (in_fabric.opcode == WR);
    assign is_rd = in_fabric_valid && (in_fabric.opcode == RD);

    assign mem_address = in_fabric.address; // Wrapper slices the word index
    assign mem_wr_data = in_fabric.data;
    assign imem_wren   = is_wr && imem_hit;
    assign dmem_wren   = is_wr && dmem_hit;

    // Track the read into the next cycle
    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            rsp_push    <= 1'b0;
            rd_imem_hit <= 1'b0;
            rd_dmem_hit <= 1'b0;
        end else begin
            rsp_push    <= is_rd; // Push lands while memory data is out
            rd_imem_hit <= is_rd && imem_hit;
            rd_dmem_hit <= is_rd && dmem_hit;
        end
    end

    // Reply goes back to the requester tile
    always_ff @(posedge Clock) begin
        if (is_rd)
            rd_rsp_addr <= {in_fabric.requestor_id, in_fabric.address[23:0]};
    end

    //======================================================================
    // Response cycle
    //======================================================================
    always_comb begin
        if (rd_imem_hit)
            rsp_data = imem_q;
        else if (rd_dmem_hit)
            rsp_data = dmem_q;
        else
            rsp_data = '0; // Unmapped region reads zero
    end

    // Stored by the response FIFO at the end of this cycle
    always_comb begin
        rsp_trans.address               = rd_rsp_addr;
        rsp_trans.data                  = rsp_data;
        rsp_trans.opcode                = RD_RSP;
        rsp_trans.requestor_id          = local_tile_id; // Responder is this tile
        rsp_trans.next_tile_fifo_arb_id = '0;
    end

endmodule

`default_nettype wire

// File: source/fabric_out_arb.sv
/*
 * Round-robin arbiter between response FIFO and core request
 * FIFO, drives one transaction per cycle onto the outgoing link
 */
`default_nettype none

module fabric_out_arb
    import tile_fabric_pkg::*;
(
    input  logic        Clock,
    input  logic        rst_n,
    // FIFO heads
    input  t_tile_trans rsp_head,
    input  t_tile_trans req_head,
    input  logic        rsp_empty,
    input  logic        req_empty,
    // Pops back to the FIFOs
    output logic        rsp_pop,
    output logic        req_pop,
    // Outgoing link, never stalls
    output t_tile_trans out_fabric,
    output logic        out_fabric_valid
);

    logic prio_rsp; // Responses first when set
    logic both_waiting;
    logic grant_rsp;
    logic grant_req;

    assign both_waiting = !rsp_empty && !req_empty;

    //======================================================================
    // Grant
    //======================================================================
    assign grant_rsp = !rsp_empty && (req_empty || prio_rsp);
    assign grant_req = !req_empty && !grant_rsp;

    assign rsp_pop          = grant_rsp;
    assign req_pop          = grant_req;
    assign out_fabric_valid = !rsp_empty || !req_empty;

    always_comb begin
        if (grant_rsp)
            out_fabric = rsp_head;
        else if (grant_req)
            out_fabric = req_head;
        else
            out_fabric = '0; // Idle link
    end

    // Flip priority only on contention
    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n)
            prio_rsp <= 1'b1;
        else if (both_waiting)
            prio_rsp <= !prio_rsp;
    end

endmodule

`default_nettype wire

// File: source/tile_fabric_pkg.sv
/*
 * Fabric side types: tile id, transaction opcodes and the
 * transaction struct carried on the inter-tile links
 */
`default_nettype none

package tile_fabric_pkg;

    // Tile identifier, top byte of a fabric address
    typedef logic [7:0] t_tile_id;

    //======================================================================
    // Opcodes
    //======================================================================
    typedef enum logic [1:0] {
        WR     = 2'b00, // Write request
        RD     = 2'b01, // Read request
        RD_RSP = 2'b10  // Read response, data back to requester
    } t_fab_op;

    //======================================================================
    // Fabric transaction
    //======================================================================
    // address[31:24] target tile, [23:16] region, [15:0] byte offset
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] data;
        t_fab_op     opcode;
        t_tile_id    requestor_id;          // Who gets the response
        logic [1:0]  next_tile_fifo_arb_id; // Router use only, zero here
    } t_tile_trans;

endpackage

`default_nettype wire

// File: source/tile_mem_pkg.sv
/*
 * Tile memory map: region field position, region bounds
 * and the core data memory request struct
 */
`default_nettype none

package tile_mem_pkg;

    //======================================================================
    // Memory map
    //======================================================================
    localparam int MSB_REGION = 23; // Region field inside the address
    localparam int LSB_REGION = 16;

    // Hit is strictly above floor and strictly below roof
    localparam int I_MEM_REGION_FLOOR = 0; // Region 1 only
    localparam int I_MEM_REGION_ROOF  = 2;
    localparam int D_MEM_REGION_FLOOR = 1; // Regions 2 and 3
    localparam int D_MEM_REGION_ROOF  = 4;

    //======================================================================
    // Core data memory port
    //======================================================================
    typedef struct packed {
        logic [31:0] address; // Byte address
        logic [31:0] wr_data;
        logic [3:0]  byte_en; // One bit per byte lane
        logic        wr_en;   // Store when set, load otherwise
    } t_core_dmem_req;

endpackage

`default_nettype wire

// File: source/tile_mem_wrap.sv
/*
 * Tile memory wrapper top: instruction and data memories,
 * fabric decode, response and request FIFOs, outgoing arbiter
 */
`default_nettype none

module tile_mem_wrap
    import tile_fabric_pkg::*;
    import tile_mem_pkg::*;
#(
    parameter int IMEM_ADRS_WIDTH = 13,
    parameter int DMEM_ADRS_WIDTH = 14,
    parameter int FIFO_DEPTH      = 2
) (
    input  logic           Clock,
    input  logic           rst_n,
    input  t_tile_id       local_tile_id,
    // Core fetch and data port
    input  logic [31:0]    pc,
    output logic [31:0]    instruction,     // One cycle after pc
    input  t_core_dmem_req dmem_req,
    output logic [31:0]    dmem_rd_data,    // One cycle after dmem_req
    // Fabric in
    input  logic           in_fabric_valid,
    input  t_tile_trans    in_fabric,
    output logic           f2c_rsp_full,    // Fabric holds reads
    // Core requests out
    input  logic           c2f_req_valid,
    input  t_tile_trans    c2f_req,
    output logic           c2f_full,        // Core holds requests
    // Fabric out
    output t_tile_trans    out_fabric,
    output logic           out_fabric_valid
);

    logic [31:0] mem_address;
    logic [31:0] mem_wr_data;
    logic        imem_wren;
    logic        dmem_wren;
    logic [31:0] imem_q;
    logic [31:0] dmem_q;
    logic        rsp_push;
    t_tile_trans rsp_trans;
    t_tile_trans rsp_head;
    t_tile_trans req_head;
    logic        rsp_empty;
    logic        req_empty;
    logic        rsp_pop;
    logic        req_pop;

    //======================================================================
    // Memories
    //======================================================================
    dual_port_mem #(.WORD_WIDTH(32), .ADRS_WIDTH(IMEM_ADRS_WIDTH)) i_mem (
        .Clock     (Clock),
        .address_a (pc[IMEM_ADRS_WIDTH+1:2]), // Fetch, read only
        .data_a    (32'h0),
        .wren_a    (1'b0),
        .byteena_a (4'b0000),
        .q_a       (instruction),
        .address_b (mem_address[IMEM_ADRS_WIDTH+1:2]),
        .data_b    (mem_wr_data),
        .wren_b    (imem_wren),
        .byteena_b (4'b1111),
        .q_b       (imem_q)
    );

    dual_port_mem #(.WORD_WIDTH(32), .ADRS_WIDTH(DMEM_ADRS_WIDTH)) d_mem (
        .Clock     (Clock),
        .address_a (dmem_req.address[DMEM_ADRS_WIDTH+1:2]),
        .data_a    (dmem_req.wr_data),
        .wren_a    (dmem_req.wr_en),
        .byteena_a (dmem_req.byte_en),
        .q_a       (dmem_rd_data),
        .address_b (mem_address[DMEM_ADRS_WIDTH+1:2]),
        .data_b    (mem_wr_data),
        .wren_b    (dmem_wren),
        .byteena_b (4'b1111),                  // Fabric writes whole words
        .q_b       (dmem_q)
    );

    //======================================================================
    // Fabric decode and outgoing path
    //======================================================================
    f2c_decode f2c_decode (
        .Clock (Clock), .rst_n (rst_n), .local_tile_id (local_tile_id),
        .in_fabric_valid (in_fabric_valid), .in_fabric (in_fabric),
        .imem_q (imem_q), .dmem_q (dmem_q),
        .mem_address (mem_address), .mem_wr_data (mem_wr_data),
        .imem_wren (imem_wren), .dmem_wren (dmem_wren),
        .rsp_push (rsp_push), .rsp_trans (rsp_trans)
    );

    trans_fifo #(.DEPTH(FIFO_DEPTH)) f2c_rsp_fifo (
        .Clock (Clock), .rst_n (rst_n), .push (rsp_push), .push_data (rsp_trans),
        .pop (rsp_pop), .pop_data (rsp_head), .full (f2c_rsp_full), .empty (rsp_empty)
    );

    trans_fifo #(.DEPTH(FIFO_DEPTH)) c2f_req_fifo (
        .Clock (Clock), .rst_n (rst_n), .push (c2f_req_valid), .push_data (c2f_req),
        .pop (req_pop), .pop_data (req_head), .full (c2f_full), .empty (req_empty)
    );

    fabric_out_arb fabric_out_arb (
        .Clock (Clock), .rst_n (rst_n),
        .rsp_head (rsp_head), .req_head (req_head),
        .rsp_empty (rsp_empty), .req_empty (req_empty),
        .rsp_pop (rsp_pop), .req_pop (req_pop),
        .out_fabric (out_fabric), .out_fabric_valid (out_fabric_valid)
    );

endmodule

`default_nettype wire

// File: source/trans_fifo.sv
/*
 * Show-ahead FIFO of fabric transactions, circular buffer
 * with occupancy count and full / empty levels
 */
`default_nettype none

module trans_fifo
    import tile_fabric_pkg::*;
#(
    parameter int DEPTH = 2
) (
    input  logic        Clock,
    input  logic        rst_n,
    input  logic        push,
    input  t_tile_trans push_data,
    input  logic        pop,
    output t_tile_trans pop_data,
    output logic        full,
    output logic        empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    t_tile_trans       entries [DEPTH]; // Payload, no reset
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop); // Full + pop frees a slot

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = entries[rd_ptr]; // Head always visible

    //======================================================================
    // Pointers and count
    //======================================================================
    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // Storage write
    always_ff @(posedge Clock) begin
        if (do_push)
            entries[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock and active-low reset generator
 */
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20, // ns, 40 ns clock
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/tile_mem_tb.sv
/*
 * Testbench for the tile memory wrapper: operation table with a
 * reference memory model, burst phase with back-pressure, and an
 * in-order monitor of the outgoing fabric link
 */
`default_nettype none

module tile_mem_tb
    import tile_fabric_pkg::*;
    import tile_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int       N_ROWS         = 18;
    localparam int       N_BURST        = 12;
    localparam int       TIMEOUT_CYCLES = (N_ROWS + N_BURST) * 8 + 200;
    localparam t_tile_id LOCAL_ID       = 8'h05;
    localparam t_tile_id REQ_ID         = 8'h0A; // Remote tile that sends reads

    typedef enum logic [2:0] {K_FAB_WR, K_FAB_RD, K_ST, K_LD, K_FETCH, K_C2F} t_kind;

    typedef struct packed {
        t_kind       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        logic [31:0] exp;  // From the reference model
    } t_row;

    logic clk, rst_n;
    t_tile_id       local_tile_id;
    logic [31:0]    pc, instruction, dmem_rd_data;
    t_core_dmem_req dmem_req;
    logic           in_fabric_valid, f2c_rsp_full, c2f_req_valid, c2f_full, out_fabric_valid;
    t_tile_trans    in_fabric, c2f_req, out_fabric, mon_exp;

    t_row        ops [N_ROWS];
    int          n_rows, value_errs, other_errs, cycles;
    logic [31:0] ref_imem [int];   // Word index -> contents
    logic [31:0] ref_dmem [int];
    t_tile_trans rsp_q [$];        // Expected RD_RSP, in order
    t_tile_trans req_q [$];        // Expected core requests, in order
    logic        saw_c2f_full;

    tb_clock_gen clock_gen (.clk (clk), .rst_n (rst_n));

    tile_mem_wrap DUT (
        .Clock (clk), .rst_n (rst_n), .local_tile_id (local_tile_id),
        .pc (pc), .instruction (instruction),
        .dmem_req (dmem_req), .dmem_rd_data (dmem_rd_data),
        .in_fabric_valid (in_fabric_valid), .in_fabric (in_fabric),
        .f2c_rsp_full (f2c_rsp_full),
        .c2f_req_valid (c2f_req_valid), .c2f_req (c2f_req), .c2f_full (c2f_full),
        .out_fabric (out_fabric), .out_fabric_valid (out_fabric_valid)
    );

    //======================================================================
    // Reference model
    //======================================================================
    // Region 1 imem, regions 2 and 3 dmem, word index from bits W+1..2
    function automatic void update_model(input t_kind kind, input logic [31:0] addr,
                                         input logic [31:0] data, input logic [3:0] be);
        logic [31:0] word;
        if (kind == K_ST) begin
            word = ref_dmem[addr[15:2]];
            for (int i = 0; i < 4; i++)
                if (be[i]) word[i*8 +: 8] = data[i*8 +: 8]; // Enabled lanes only
            ref_dmem[addr[15:2]] = word;
        end else if (kind == K_FAB_WR) begin
            if (addr[23:16] == 8'd1)
                ref_imem[addr[14:2]] = data;
            else if (addr[23:16] == 8'd2 || addr[23:16] == 8'd3)
                ref_dmem[addr[15:2]] = data;
        end
    endfunction

    function automatic logic [31:0] expected_read(input t_kind kind, input logic [31:0] addr);
        if (kind == K_FETCH)
            return ref_imem[addr[14:2]];
        if (kind == K_LD)
            return ref_dmem[addr[15:2]];
        if (addr[23:16] == 8'd1)
            return ref_imem[addr[14:2]];
        if (addr[23:16] == 8'd2 || addr[23:16] == 8'd3)
            return ref_dmem[addr[15:2]];
        return 32'h0; // Unmapped region
    endfunction

    task automatic add_row(input t_kind kind, input logic [31:0] addr, input logic [3:0] be);
        t_row row;
        row.kind = kind;
        row.addr = addr;
        row.data = $urandom();
        row.be   = be;
        update_model(kind, addr, row.data, be);
        row.exp  = expected_read(kind, addr);
        ops[n_rows] = row;
        n_rows++;
    endtask

    //======================================================================
    // Drive and check helpers
    //======================================================================
    task automatic idle_inputs();
        in_fabric_valid = 1'b0;
        in_fabric       = '0;
        c2f_req_valid   = 1'b0;
        c2f_req         = '0;
        dmem_req.wr_en  = 1'b0; // Address kept, loads are harmless
    endtask

    task automatic verify_word(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
        end
    endtask

    // Fabric read into the response expectation queue
    task automatic send_fabric(input t_fab_op op, input logic [31:0] addr,
                               input logic [31:0] data, input logic [31:0] exp);
        t_tile_trans tr;
        in_fabric.address      = addr;
        in_fabric.data         = data;
        in_fabric.opcode       = op;
        in_fabric.requestor_id = REQ_ID;
        in_fabric_valid        = 1'b1;
        if (op == RD) begin
            tr.address               = {REQ_ID, addr[23:0]}; // Back to requester
            tr.data                  = exp;
            tr.opcode                = RD_RSP;
            tr.requestor_id          = LOCAL_ID;
            tr.next_tile_fifo_arb_id = 2'b00;
            rsp_q.push_back(tr);
        end
    endtask

    task automatic send_core_req(input logic [31:0] addr, input logic [31:0] data);
        t_tile_trans tr;
        tr.address               = addr;
        tr.data                  = data;
        tr.opcode                = WR;
        tr.requestor_id          = LOCAL_ID;
        tr.next_tile_fifo_arb_id = 2'b00;
        c2f_req       = tr;
        c2f_req_valid = 1'b1;
        req_q.push_back(tr); // Must leave unchanged
    endtask

    // One row over two cycles, result checked one cycle after the request
    task automatic run_row(input t_row row);
        @(posedge clk);
        #5;
        case (row.kind)
            K_FAB_WR: send_fabric(WR, row.addr, row.data, 32'h0);
            K_FAB_RD: send_fabric(RD, row.addr, row.data, row.exp);
            K_ST: begin
                dmem_req.address = row.addr;
                dmem_req.wr_data = row.data;
                dmem_req.byte_en = row.be;
                dmem_req.wr_en   = 1'b1;
            end
            K_LD:    dmem_req.address = row.addr;
            K_FETCH: pc = row.addr;
            K_C2F:   send_core_req(row.addr, row.data);
            default: ;
        endcase
        @(posedge clk);
        #5;
        idle_inputs();
        @(negedge clk);
        if (row.kind == K_FETCH)
            verify_word("instruction", row.exp, instruction);
        else if (row.kind == K_LD)
            verify_word("dmem_rd_data", row.exp, dmem_rd_data);
    endtask

    // Core requests every cycle and fabric reads every other cycle
    task automatic burst_traffic();
        logic [31:0] rd_addr;
        int          sent;
        int          cyc;
        sent = 0;
        cyc  = 0;
        while (sent < N_BURST) begin
            @(posedge clk);
            #5;
            idle_inputs();
            if (c2f_full)
                saw_c2f_full = 1'b1; // Core holds this cycle
            else begin
                send_core_req(32'h0900_0000 + 32'(sent * 4), $urandom());
                sent++;
            end
            if (!cyc[0] && !f2c_rsp_full) begin
                rd_addr = cyc[1] ? 32'h0501_0000 : 32'h0502_0010;
                send_fabric(RD, rd_addr, 32'h0, expected_read(K_FAB_RD, rd_addr));
            end
            cyc++;
        end
        @(posedge clk);
        #5;
        idle_inputs();
    endtask

    //======================================================================
    // Outgoing link monitor, two independent ordered streams
    //======================================================================
    always @(negedge clk) begin
        if (rst_n === 1'b1 && out_fabric_valid === 1'b1) begin
            if (out_fabric.opcode == RD_RSP && rsp_q.size() == 0) begin
                other_errs++;
                $display("Unexpected read response on out_fabric at %0t", $time);
            end else if (out_fabric.opcode != RD_RSP && req_q.size() == 0) begin
                other_errs++;
                $display("Unexpected core request on out_fabric at %0t", $time);
            end else begin
                mon_exp = (out_fabric.opcode == RD_RSP) ? rsp_q.pop_front() : req_q.pop_front();
                if (out_fabric !== mon_exp) begin
                    value_errs++;
                    $display("ERR %0t out_fabric exp %h got %h", $time, mon_exp, out_fabric);
                end
            end
        end
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles <= TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, outgoing transactions still missing", cycles);
        $display(">>> FAIL");
        $finish;
    end

    //======================================================================
    // Main sequence
    //======================================================================
    initial begin
        value_errs    = 0;
        other_errs    = 0;
        n_rows        = 0;
        saw_c2f_full  = 1'b0;
        local_tile_id = LOCAL_ID;
        pc            = '0;
        dmem_req      = '0;
        idle_inputs();
        void'($urandom(32'h99db41f0));

        add_row(K_FAB_WR, 32'h0501_0000, 4'hF); // Instruction words
        add_row(K_FAB_WR, 32'h0501_0004, 4'hF);
        add_row(K_FAB_WR, 32'h0502_0010, 4'hF); // Data word 4
        add_row(K_FAB_WR, 32'h0503_0020, 4'hF); // Data word 8 via region 3
        add_row(K_FETCH,  32'h0000_0000, 4'hF);
        add_row(K_FETCH,  32'h0000_0004, 4'hF);
        add_row(K_LD,     32'h0000_0010, 4'hF);
        add_row(K_LD,     32'h0000_0020, 4'hF);
        add_row(K_ST,     32'h0000_0010, 4'b0101); // Partial lanes
        add_row(K_ST,     32'h0000_0020, 4'b1000);
        add_row(K_LD,     32'h0000_0010, 4'hF);
        add_row(K_FAB_RD, 32'h0502_0010, 4'hF);    // Merged words
        add_row(K_FAB_RD, 32'h0503_0020, 4'hF);
        add_row(K_FAB_RD, 32'h0501_0004, 4'hF);
        add_row(K_FAB_RD, 32'h0500_0010, 4'hF);    // Unmapped, reads zero
        add_row(K_FAB_RD, 32'h0504_0010, 4'hF);
        add_row(K_C2F,    32'h0700_0040, 4'hF);
        add_row(K_C2F,    32'h0700_0044, 4'hF);

        wait (rst_n === 1'b1);
        @(negedge clk);
        verify_word("out_fabric_valid", 32'h0, {31'h0, out_fabric_valid});
        verify_word("c2f_full", 32'h0, {31'h0, c2f_full});
        verify_word("f2c_rsp_full", 32'h0, {31'h0, f2c_rsp_full});

        for (int i = 0; i < n_rows; i++)
            run_row(ops[i]);
        burst_traffic();

        // Drain both streams, the run limit catches a lost transaction
        while (rsp_q.size() != 0 || req_q.size() != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);
        verify_word("out_fabric_valid", 32'h0, {31'h0, out_fabric_valid});
        if (!saw_c2f_full) begin
            other_errs++;
            $display("c2f_full never rose while the request FIFO was filling");
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
